/* hdl/mipsPkg.sv */
package mipsPkg;

    // data word, also used for hi, lo and pc values
    typedef logic [31:0] word_t;

    // register file index
    typedef logic [4:0] regAddr_t;

    // jump and branch link target
    localparam regAddr_t linkReg = 5'd31;

    typedef enum logic [3:0] {
        aluAdd,
        aluAddu,
        aluSub,
        aluSubu,
        aluAnd,
        aluOr,
        aluXor,
        aluNor,
        aluSlt,
        aluSltu,
        aluSll,
        aluSrl,
        aluSra,
        aluLui,
        aluPassB
    } aluFunc_t;

    typedef enum logic {
        srcBReg,
        srcBImm
    } aluSrcB_t;

    typedef enum logic {
        dstRt,
        dstRd
    } regDst_t;

    // operand B only ever sees the first three
    typedef enum logic [2:0] {
        fwdDecode,
        fwdMem,
        fwdWb,
        fwdHiM,
        fwdLoM,
        fwdHiW,
        fwdLoW
    } forward_t;

    typedef enum logic [2:0] {
        mdNone,
        mdMult,
        mdMultu,
        mdDiv,
        mdDivu
    } mdOp_t;

    typedef enum logic [1:0] {
        divIdle,
        divBusy,
        divDone
    } divState_t;

endpackage

/* hdl/operandForward.sv */
`timescale 1ns/1ps

module operandForward (
    input  mipsPkg::forward_t sel,
    input  mipsPkg::word_t    decodeValue,
    input  mipsPkg::word_t    memValue,
    input  mipsPkg::word_t    wbValue,
    input  mipsPkg::word_t    hiM,
    input  mipsPkg::word_t    loM,
    input  mipsPkg::word_t    hiW,
    input  mipsPkg::word_t    loW,
    output mipsPkg::word_t    operand
);

    // select driven by the hazard unit
    always_comb begin
        case (sel)
            mipsPkg::fwdMem: begin
                operand = memValue;
            end
            mipsPkg::fwdWb: begin
                operand = wbValue;
            end
            // hi/lo paths serve mfhi and mflo
            mipsPkg::fwdHiM: begin
                operand = hiM;
            end
            mipsPkg::fwdLoM: begin
                operand = loM;
            end
            mipsPkg::fwdHiW: begin
                operand = hiW;
            end
            mipsPkg::fwdLoW: begin
                operand = loW;
            end
            default: begin
                operand = decodeValue;
            end
        endcase
    end

endmodule

/* hdl/alu.sv */
`timescale 1ns/1ps

module alu (
    input  mipsPkg::word_t    a,
    input  mipsPkg::word_t    b,
    input  mipsPkg::aluFunc_t func,
    output mipsPkg::word_t    result,
    output logic              overflow
);

    mipsPkg::word_t sum;
    mipsPkg::word_t diff;
    logic           addOvf;
    logic           subOvf;

    assign sum  = a + b;
    assign diff = a - b;

    // same-sign inputs giving an opposite-sign sum
    assign addOvf = (a[31] == b[31]) && (sum[31] != a[31]);
    assign subOvf = (a[31] != b[31]) && (diff[31] != a[31]);

    always_comb begin
        case (func)
            mipsPkg::aluAdd, mipsPkg::aluAddu: begin
                result = sum;
            end
            mipsPkg::aluSub, mipsPkg::aluSubu: begin
                result = diff;
            end
            mipsPkg::aluAnd: begin
                result = a & b;
            end
            mipsPkg::aluOr: begin
                result = a | b;
            end
            mipsPkg::aluXor: begin
                result = a ^ b;
            end
            mipsPkg::aluNor: begin
                result = ~(a | b);
            end
            mipsPkg::aluSlt: begin
                result = {31'b0, $signed(a) < $signed(b)};
            end
            mipsPkg::aluSltu: begin
                result = {31'b0, a < b};
            end
            // shift amount comes in on a
            mipsPkg::aluSll: begin
                result = b << a[4:0];
            end
            mipsPkg::aluSrl: begin
                result = b >> a[4:0];
            end
            mipsPkg::aluSra: begin
                result = $signed(b) >>> a[4:0];
            end
            mipsPkg::aluLui: begin
                result = {b[15:0], 16'b0};
            end
            default: begin
                result = b;
            end
        endcase
    end

    // unsigned forms never trap
    assign overflow = ((func == mipsPkg::aluAdd) && addOvf)
                    || ((func == mipsPkg::aluSub) && subOvf);

endmodule

/* hdl/multDiv.sv */
`timescale 1ns/1ps

module multDiv (
    input  logic              clk,
    input  logic              reset,
    input  mipsPkg::word_t    a,
    input  mipsPkg::word_t    b,
    input  mipsPkg::mdOp_t    op,
    output mipsPkg::word_t    hi,
    output mipsPkg::word_t    lo,
    output logic              stall
);

    mipsPkg::divState_t state;
    logic [4:0]         stepCount;
    logic               isDiv;
    logic               isSigned;
    logic [63:0]        product;
    mipsPkg::word_t     divisorMag;
    mipsPkg::word_t     dividendReg;
    mipsPkg::word_t     quotReg;
    mipsPkg::word_t     remReg;
    logic               negQuot;
    logic               negRem;
    logic               divByZero;
    logic [32:0]        partial;
    logic               stepGe;

    assign isDiv    = (op == mipsPkg::mdDiv) || (op == mipsPkg::mdDivu);
    assign isSigned = (op == mipsPkg::mdDiv);

    // stall from the first cycle of a divide until the quotient is ready
    assign stall = isDiv && (state != mipsPkg::divDone);

    // one restoring step: shift in the next dividend bit and try to subtract
    assign partial = {remReg, quotReg[31]};
    assign stepGe  = partial >= {1'b0, divisorMag};

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= mipsPkg::divIdle;
            stepCount <= 5'd0;
        end else begin
            case (state)
                mipsPkg::divIdle: begin
                    if (isDiv) begin
                        state     <= mipsPkg::divBusy;
                        stepCount <= 5'd0;
                    end
                end
                mipsPkg::divBusy: begin
                    stepCount <= stepCount + 5'd1;
                    if (stepCount == 5'd31) begin
                        state <= mipsPkg::divDone;
                    end
                end
                // result is taken at this edge
                default: begin
                    state <= mipsPkg::divIdle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == mipsPkg::divIdle) begin
            // start cycle loads magnitudes and sign info
            quotReg     <= (isSigned && a[31]) ? -a : a;
            divisorMag  <= (isSigned && b[31]) ? -b : b;
            remReg      <= '0;
            dividendReg <= a;
            negQuot     <= isSigned && (a[31] ^ b[31]);
            negRem      <= isSigned && a[31];
            divByZero   <= (b == '0);
        end else if (state == mipsPkg::divBusy) begin
            remReg  <= stepGe ? 32'(partial - {1'b0, divisorMag}) : partial[31:0];
            quotReg <= {quotReg[30:0], stepGe};
        end
    end

    // sign-extend or zero-extend to 64 bits and keep the low product
    assign product = (op == mipsPkg::mdMult)
                   ? {{32{a[31]}}, a} * {{32{b[31]}}, b}
                   : {32'b0, a} * {32'b0, b};

    always_comb begin
        hi = '0;
        lo = '0;
        if ((op == mipsPkg::mdMult) || (op == mipsPkg::mdMultu)) begin
            hi = product[63:32];
            lo = product[31:0];
        end else if (isDiv && (state == mipsPkg::divDone)) begin
            if (divByZero) begin
                hi = dividendReg;
                lo = '1;
            end else begin
                // quotient truncates toward zero, remainder follows dividend
                hi = negRem ? -remReg : remReg;
                lo = negQuot ? -quotReg : quotReg;
            end
        end
    end

endmodule

/* hdl/execute.sv */
`timescale 1ns/1ps

module execute (
    input  logic              clk,
    input  logic              reset,
    input  mipsPkg::word_t    srcA,
    input  mipsPkg::word_t    srcB,
    input  mipsPkg::word_t    imm,
    input  logic [4:0]        shamt,
    input  logic              shamtValid,
    input  mipsPkg::aluFunc_t aluFunc,
    input  mipsPkg::aluSrcB_t aluSrcB,
    input  mipsPkg::mdOp_t    mdOp,
    input  mipsPkg::regDst_t  regDst,
    input  mipsPkg::regAddr_t rt,
    input  mipsPkg::regAddr_t rd,
    input  logic              jump,
    input  mipsPkg::word_t    pcPlus4,
    input  mipsPkg::forward_t forwardA,
    input  mipsPkg::forward_t forwardB,
    input  mipsPkg::word_t    aluOutM,
    input  mipsPkg::word_t    resultW,
    input  mipsPkg::word_t    hiM,
    input  mipsPkg::word_t    loM,
    input  mipsPkg::word_t    hiW,
    input  mipsPkg::word_t    loW,
    output mipsPkg::word_t    exAluOut,
    output mipsPkg::regAddr_t exWriteReg,
    output mipsPkg::word_t    exWriteData,
    output mipsPkg::word_t    exHi,
    output mipsPkg::word_t    exLo,
    output logic              exOverflow,
    output logic              stall
);

    mipsPkg::word_t fwdA;
    mipsPkg::word_t fwdB;
    mipsPkg::word_t aluA;
    mipsPkg::word_t aluB;
    mipsPkg::word_t aluResult;

    operandForward fwdMuxA (
        .sel         (forwardA),
        .decodeValue (srcA),
        .memValue    (aluOutM),
        .wbValue     (resultW),
        .hiM         (hiM),
        .loM         (loM),
        .hiW         (hiW),
        .loW         (loW),
        .operand     (fwdA)
    );

    // hi/lo are never forwarded into B
    operandForward fwdMuxB (
        .sel         (forwardB),
        .decodeValue (srcB),
        .memValue    (aluOutM),
        .wbValue     (resultW),
        .hiM         ('0),
        .loM         ('0),
        .hiW         ('0),
        .loW         ('0),
        .operand     (fwdB)
    );

    // shift-immediate forms take the amount from the instruction
    assign aluA = shamtValid ? {27'b0, shamt} : fwdA;
    assign aluB = (aluSrcB == mipsPkg::srcBImm) ? imm : fwdB;

    alu alu0 (
        .a        (aluA),
        .b        (aluB),
        .func     (aluFunc),
        .result   (aluResult),
        .overflow (exOverflow)
    );

    multDiv multDiv0 (
        .clk   (clk),
        .reset (reset),
        .a     (aluA),
        .b     (aluB),
        .op    (mdOp),
        .hi    (exHi),
        .lo    (exLo),
        .stall (stall)
    );

    // link address skips the delay slot
    assign exAluOut    = jump ? pcPlus4 + 32'd4 : aluResult;
    assign exWriteReg  = jump ? mipsPkg::linkReg
                       : (regDst == mipsPkg::dstRd) ? rd : rt;
    assign exWriteData = fwdB;

endmodule

/* hdl/execMemReg.sv */
`timescale 1ns/1ps

module execMemReg (
    input  logic              clk,
    input  logic              reset,
    input  logic              flush,
    input  logic              stall,
    input  logic              inValid,
    input  mipsPkg::word_t    exAluOut,
    input  mipsPkg::regAddr_t exWriteReg,
    input  mipsPkg::word_t    exWriteData,
    input  mipsPkg::word_t    exHi,
    input  mipsPkg::word_t    exLo,
    input  logic              exOverflow,
    input  mipsPkg::word_t    pcPlus4,
    output logic              memValid,
    output mipsPkg::word_t    memAluOut,
    output mipsPkg::regAddr_t memWriteReg,
    output mipsPkg::word_t    memWriteData,
    output mipsPkg::word_t    memHi,
    output mipsPkg::word_t    memLo,
    output logic              memOverflow,
    output mipsPkg::word_t    memPcPlus4
);

    always_ff @(posedge clk) begin
        // a stalled or flushed cycle becomes a zeroed bubble
        if (reset || flush || stall) begin
            memValid     <= 1'b0;
            memAluOut    <= '0;
            memWriteReg  <= '0;
            memWriteData <= '0;
            memHi        <= '0;
            memLo        <= '0;
            memOverflow  <= 1'b0;
            memPcPlus4   <= '0;
        end else begin
            memValid     <= inValid;
            memAluOut    <= exAluOut;
            memWriteReg  <= exWriteReg;
            memWriteData <= exWriteData;
            memHi        <= exHi;
            memLo        <= exLo;
            memOverflow  <= exOverflow;
            memPcPlus4   <= pcPlus4;
        end
    end

endmodule

/* hdl/execUnit.sv */
`timescale 1ns/1ps

module execUnit (
    input  logic              clk,
    input  logic              reset,
    input  logic              inValid,
    input  mipsPkg::word_t    srcA,
    input  mipsPkg::word_t    srcB,
    input  mipsPkg::word_t    imm,
    input  logic [4:0]        shamt,
    input  logic              shamtValid,
    input  mipsPkg::aluFunc_t aluFunc,
    input  mipsPkg::aluSrcB_t aluSrcB,
    input  mipsPkg::mdOp_t    mdOp,
    input  mipsPkg::regDst_t  regDst,
    input  mipsPkg::regAddr_t rt,
    input  mipsPkg::regAddr_t rd,
    input  logic              jump,
    input  mipsPkg::word_t    pcPlus4,
    input  mipsPkg::forward_t forwardA,
    input  mipsPkg::forward_t forwardB,
    input  mipsPkg::word_t    aluOutM,
    input  mipsPkg::word_t    resultW,
    input  mipsPkg::word_t    hiM,
    input  mipsPkg::word_t    loM,
    input  mipsPkg::word_t    hiW,
    input  mipsPkg::word_t    loW,
    input  logic              flush,
    output logic              stall,
    output logic              memValid,
    output mipsPkg::word_t    memAluOut,
    output mipsPkg::regAddr_t memWriteReg,
    output mipsPkg::word_t    memWriteData,
    output mipsPkg::word_t    memHi,
    output mipsPkg::word_t    memLo,
    output logic              memOverflow,
    output mipsPkg::word_t    memPcPlus4
);

    mipsPkg::word_t    exAluOut;
    mipsPkg::regAddr_t exWriteReg;
    mipsPkg::word_t    exWriteData;
    mipsPkg::word_t    exHi;
    mipsPkg::word_t    exLo;
    logic              exOverflow;

    execute execute0 (
        .clk         (clk),
        .reset       (reset),
        .srcA        (srcA),
        .srcB        (srcB),
        .imm         (imm),
        .shamt       (shamt),
        .shamtValid  (shamtValid),
        .aluFunc     (aluFunc),
        .aluSrcB     (aluSrcB),
        .mdOp        (mdOp),
        .regDst      (regDst),
        .rt          (rt),
        .rd          (rd),
        .jump        (jump),
        .pcPlus4     (pcPlus4),
        .forwardA    (forwardA),
        .forwardB    (forwardB),
        .aluOutM     (aluOutM),
        .resultW     (resultW),
        .hiM         (hiM),
        .loM         (loM),
        .hiW         (hiW),
        .loW         (loW),
        .exAluOut    (exAluOut),
        .exWriteReg  (exWriteReg),
        .exWriteData (exWriteData),
        .exHi        (exHi),
        .exLo        (exLo),
        .exOverflow  (exOverflow),
        .stall       (stall)
    );

    // stall also turns the register input into a bubble
    execMemReg execMemReg0 (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .stall        (stall),
        .inValid      (inValid),
        .exAluOut     (exAluOut),
        .exWriteReg   (exWriteReg),
        .exWriteData  (exWriteData),
        .exHi         (exHi),
        .exLo         (exLo),
        .exOverflow   (exOverflow),
        .pcPlus4      (pcPlus4),
        .memValid     (memValid),
        .memAluOut    (memAluOut),
        .memWriteReg  (memWriteReg),
        .memWriteData (memWriteData),
        .memHi        (memHi),
        .memLo        (memLo),
        .memOverflow  (memOverflow),
        .memPcPlus4   (memPcPlus4)
    );

endmodule

/* tests/clockGen.sv */
`timescale 1ns/1ps

module clockGen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // held for two rising edges
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

/* tests/execUnitTb.sv */
`timescale 1ns/1ps

module execUnitTb;

    typedef struct packed {
        mipsPkg::word_t    aluOut;
        mipsPkg::regAddr_t writeReg;
        mipsPkg::word_t    writeData;
        mipsPkg::word_t    hi;
        mipsPkg::word_t    lo;
        logic              overflow;
        mipsPkg::word_t    pcPlus4;
    } expect_t;

    localparam int maxCycles = 4000;

    logic              clk;
    logic              reset;
    logic              inValid;
    mipsPkg::word_t    srcA;
    mipsPkg::word_t    srcB;
    mipsPkg::word_t    imm;
    logic [4:0]        shamt;
    logic              shamtValid;
    mipsPkg::aluFunc_t aluFunc;
    mipsPkg::aluSrcB_t aluSrcB;
    mipsPkg::mdOp_t    mdOp;
    mipsPkg::regDst_t  regDst;
    mipsPkg::regAddr_t rt;
    mipsPkg::regAddr_t rd;
    logic              jump;
    mipsPkg::word_t    pcPlus4;
    mipsPkg::forward_t forwardA;
    mipsPkg::forward_t forwardB;
    mipsPkg::word_t    aluOutM;
    mipsPkg::word_t    resultW;
    mipsPkg::word_t    hiM;
    mipsPkg::word_t    loM;
    mipsPkg::word_t    hiW;
    mipsPkg::word_t    loW;
    logic              flush;
    logic              stall;
    logic              memValid;
    mipsPkg::word_t    memAluOut;
    mipsPkg::regAddr_t memWriteReg;
    mipsPkg::word_t    memWriteData;
    mipsPkg::word_t    memHi;
    mipsPkg::word_t    memLo;
    logic              memOverflow;
    mipsPkg::word_t    memPcPlus4;

    expect_t expQ[$];
    expect_t got;
    integer  seed = 71;
    int      errCount = 0;
    int      testsPassed = 0;
    int      testsFailed = 0;
    int      errAtStart = 0;
    int      cycles = 0;

    // signed overflow corners for add and sub
    mipsPkg::word_t cornerA[6] = '{32'h7fffffff, 32'h80000000, 32'h80000000,
                                   32'h7fffffff, 32'h00000000, 32'hffffffff};
    mipsPkg::word_t cornerB[6] = '{32'h00000001, 32'h80000000, 32'h00000001,
                                   32'hffffffff, 32'h00000000, 32'hffffffff};

    clockGen clockGen0 (
        .clk   (clk),
        .reset (reset)
    );

    execUnit dut0 (
        .clk          (clk),
        .reset        (reset),
        .inValid      (inValid),
        .srcA         (srcA),
        .srcB         (srcB),
        .imm          (imm),
        .shamt        (shamt),
        .shamtValid   (shamtValid),
        .aluFunc      (aluFunc),
        .aluSrcB      (aluSrcB),
        .mdOp         (mdOp),
        .regDst       (regDst),
        .rt           (rt),
        .rd           (rd),
        .jump         (jump),
        .pcPlus4      (pcPlus4),
        .forwardA     (forwardA),
        .forwardB     (forwardB),
        .aluOutM      (aluOutM),
        .resultW      (resultW),
        .hiM          (hiM),
        .loM          (loM),
        .hiW          (hiW),
        .loW          (loW),
        .flush        (flush),
        .stall        (stall),
        .memValid     (memValid),
        .memAluOut    (memAluOut),
        .memWriteReg  (memWriteReg),
        .memWriteData (memWriteData),
        .memHi        (memHi),
        .memLo        (memLo),
        .memOverflow  (memOverflow),
        .memPcPlus4   (memPcPlus4)
    );

    // expected stage outputs from the instruction fields and stage values
    function automatic expect_t expectedResult(
        input mipsPkg::word_t a0, input mipsPkg::word_t b0, input mipsPkg::word_t immV,
        input logic [4:0] sh, input logic shV, input mipsPkg::aluFunc_t f,
        input mipsPkg::aluSrcB_t bSel, input mipsPkg::mdOp_t md,
        input mipsPkg::regDst_t dst, input mipsPkg::regAddr_t rtV,
        input mipsPkg::regAddr_t rdV, input logic jmp, input mipsPkg::word_t pc4,
        input mipsPkg::forward_t fa, input mipsPkg::forward_t fb,
        input mipsPkg::word_t memV, input mipsPkg::word_t wbV,
        input mipsPkg::word_t hiMV, input mipsPkg::word_t loMV,
        input mipsPkg::word_t hiWV, input mipsPkg::word_t loWV);
        expect_t        e;
        mipsPkg::word_t opA;
        mipsPkg::word_t opB;
        mipsPkg::word_t a;
        mipsPkg::word_t b;
        longint         sa;
        longint         sb;
        longint         r;
        logic [63:0]    u;
        case (fa)
            mipsPkg::fwdMem: opA = memV;
            mipsPkg::fwdWb:  opA = wbV;
            mipsPkg::fwdHiM: opA = hiMV;
            mipsPkg::fwdLoM: opA = loMV;
            mipsPkg::fwdHiW: opA = hiWV;
            mipsPkg::fwdLoW: opA = loWV;
            default:         opA = a0;
        endcase
        case (fb)
            mipsPkg::fwdMem: opB = memV;
            mipsPkg::fwdWb:  opB = wbV;
            default:         opB = b0;
        endcase
        a = shV ? {27'b0, sh} : opA;
        b = (bSel == mipsPkg::srcBImm) ? immV : opB;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        e = '0;
        case (f)
            mipsPkg::aluAdd, mipsPkg::aluAddu: begin
                r = sa + sb;
                e.aluOut = r[31:0];
                e.overflow = (f == mipsPkg::aluAdd) && (r[32] != r[31]);
            end
            mipsPkg::aluSub, mipsPkg::aluSubu: begin
                r = sa - sb;
                e.aluOut = r[31:0];
                e.overflow = (f == mipsPkg::aluSub) && (r[32] != r[31]);
            end
            mipsPkg::aluAnd:  e.aluOut = a & b;
            mipsPkg::aluOr:   e.aluOut = a | b;
            mipsPkg::aluXor:  e.aluOut = a ^ b;
            mipsPkg::aluNor:  e.aluOut = ~(a | b);
            mipsPkg::aluSlt:  e.aluOut = (sa < sb) ? 32'd1 : 32'd0;
            mipsPkg::aluSltu: e.aluOut = ({32'b0, a} < {32'b0, b}) ? 32'd1 : 32'd0;
            mipsPkg::aluSll:  e.aluOut = b << a[4:0];
            mipsPkg::aluSrl:  e.aluOut = b >> a[4:0];
            mipsPkg::aluSra: begin
                r = sb >>> a[4:0];
                e.aluOut = r[31:0];
            end
            mipsPkg::aluLui:  e.aluOut = {b[15:0], 16'h0000};
            default:          e.aluOut = b;
        endcase
        case (md)
            mipsPkg::mdMult: begin
                r = sa * sb;
                {e.hi, e.lo} = r;
            end
            mipsPkg::mdMultu: begin
                u = {32'b0, a} * {32'b0, b};
                {e.hi, e.lo} = u;
            end
            mipsPkg::mdDiv, mipsPkg::mdDivu: begin
                if (b == 32'd0) begin
                    e.lo = 32'hffffffff;
                    e.hi = a;
                end else if (md == mipsPkg::mdDiv) begin
                    r = sa / sb;
                    e.lo = r[31:0];
                    r = sa % sb;
                    e.hi = r[31:0];
                end else begin
                    e.lo = a / b;
                    e.hi = a % b;
                end
            end
            default: ;
        endcase
        if (jmp) begin
            e.aluOut = pc4 + 32'd4;
            e.writeReg = 5'd31;
        end else begin
            e.writeReg = (dst == mipsPkg::dstRd) ? rdV : rtV;
        end
        e.writeData = opB;
        e.pcPlus4 = pc4;
        return e;
    endfunction

    task automatic checkWord(input string what, input mipsPkg::word_t actual,
                             input mipsPkg::word_t expected);
        if (actual !== expected) begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, actual, expected);
            errCount++;
        end
    endtask

    task automatic checkReg(input string what, input mipsPkg::regAddr_t actual,
                            input mipsPkg::regAddr_t expected);
        if (actual !== expected) begin
            $display("ERR %0t: %s is %0d, expected %0d", $time, what, actual, expected);
            errCount++;
        end
    endtask

    task automatic checkFlag(input string what, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("ERR %0t: %s is %b, expected %b", $time, what, actual, expected);
            errCount++;
        end
    endtask

    // compares each valid result one edge after it was accepted
    always @(negedge clk) begin
        if (!reset && memValid) begin
            if (expQ.size() == 0) begin
                $display("At %0t memValid was high where a bubble was expected", $time);
                errCount++;
            end else begin
                got = expQ.pop_front();
                checkWord("memAluOut", memAluOut, got.aluOut);
                checkReg("memWriteReg", memWriteReg, got.writeReg);
                checkWord("memWriteData", memWriteData, got.writeData);
                checkWord("memHi", memHi, got.hi);
                checkWord("memLo", memLo, got.lo);
                checkFlag("memOverflow", memOverflow, got.overflow);
                checkWord("memPcPlus4", memPcPlus4, got.pcPlus4);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= maxCycles) begin
            $display("The run took longer than %0d cycles and was stopped", maxCycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic randomizeFields();
        mipsPkg::word_t r;
        srcA = $random(seed);
        srcB = $random(seed);
        imm = $random(seed);
        aluOutM = $random(seed);
        resultW = $random(seed);
        hiM = $random(seed);
        loM = $random(seed);
        hiW = $random(seed);
        loW = $random(seed);
        pcPlus4 = $random(seed);
        r = $random(seed);
        rt = r[4:0];
        rd = r[9:5];
        shamt = r[14:10];
        regDst = mipsPkg::regDst_t'(r[15]);
    endtask

    task automatic setPlain();
        shamtValid = 1'b0;
        aluSrcB = mipsPkg::srcBReg;
        mdOp = mipsPkg::mdNone;
        jump = 1'b0;
        forwardA = mipsPkg::fwdDecode;
        forwardB = mipsPkg::fwdDecode;
    endtask

    // called 1 ns after a rising edge, returns at the same point
    task automatic issue();
        expect_t e;
        e = expectedResult(srcA, srcB, imm, shamt, shamtValid, aluFunc, aluSrcB, mdOp,
                           regDst, rt, rd, jump, pcPlus4, forwardA, forwardB,
                           aluOutM, resultW, hiM, loM, hiW, loW);
        inValid = 1'b1;
        @(negedge clk);
        if ((mdOp == mipsPkg::mdDiv || mdOp == mipsPkg::mdDivu) && !stall) begin
            $display("At %0t a divide did not raise stall", $time);
            errCount++;
        end
        while (stall) @(negedge clk);
        expQ.push_back(e);
        @(posedge clk);
        #1;
    endtask

    task automatic endTest(input string name);
        inValid = 1'b0;
        mdOp = mipsPkg::mdNone;
        while (expQ.size() != 0) @(negedge clk);
        @(posedge clk);
        #1;
        if (errCount == errAtStart) begin
            testsPassed++;
            $display("test %s: passed", name);
        end else begin
            testsFailed++;
            $display("test %s: failed", name);
        end
        errAtStart = errCount;
    endtask

    task automatic checkBubble(input string when);
        checkFlag({when, " memValid"}, memValid, 1'b0);
        checkWord({when, " memAluOut"}, memAluOut, '0);
        checkReg({when, " memWriteReg"}, memWriteReg, '0);
        checkWord({when, " memWriteData"}, memWriteData, '0);
        checkWord({when, " memHi"}, memHi, '0);
        checkWord({when, " memLo"}, memLo, '0);
        checkFlag({when, " memOverflow"}, memOverflow, 1'b0);
        checkWord({when, " memPcPlus4"}, memPcPlus4, '0);
    endtask

    initial begin
        inValid = 1'b0;
        flush = 1'b0;
        aluFunc = mipsPkg::aluAdd;
        regDst = mipsPkg::dstRt;
        srcA = '0;
        srcB = '0;
        imm = '0;
        shamt = '0;
        rt = '0;
        rd = '0;
        pcPlus4 = '0;
        aluOutM = '0;
        resultW = '0;
        hiM = '0;
        loM = '0;
        hiW = '0;
        loW = '0;
        setPlain();
        @(negedge clk);
        while (reset) @(negedge clk);
        checkBubble("after reset");
        checkFlag("stall after reset", stall, 1'b0);
        @(posedge clk);
        #1;
        endTest("reset");

        // every ALU operation on register operands
        for (int f = 0; f < 15; f++) begin
            for (int i = 0; i < 40; i++) begin
                randomizeFields();
                setPlain();
                aluFunc = mipsPkg::aluFunc_t'(f);
                if (i < 6) begin
                    srcA = cornerA[i];
                    srcB = cornerB[i];
                end
                issue();
            end
        end
        endTest("alu operations");

        for (int i = 0; i < 30; i++) begin
            randomizeFields();
            setPlain();
            aluFunc = mipsPkg::aluFunc_t'(i % 15);
            aluSrcB = mipsPkg::srcBImm;
            shamtValid = (i % 3 == 0);
            issue();
        end
        endTest("immediate and shift amount");

        for (int fa = 0; fa < 7; fa++) begin
            for (int fb = 0; fb < 3; fb++) begin
                randomizeFields();
                setPlain();
                aluFunc = mipsPkg::aluAddu;
                forwardA = mipsPkg::forward_t'(fa);
                forwardB = mipsPkg::forward_t'(fb);
                issue();
            end
        end
        endTest("forwarding");

        for (int i = 0; i < 15; i++) begin
            randomizeFields();
            setPlain();
            aluFunc = mipsPkg::aluFunc_t'(i);
            jump = 1'b1;
            issue();
        end
        endTest("jump link");

        for (int i = 0; i < 40; i++) begin
            randomizeFields();
            setPlain();
            aluFunc = mipsPkg::aluAddu;
            mdOp = mipsPkg::mdOp_t'(1 + i % 4);
            if (i < 6) begin
                srcA = cornerA[i];
                srcB = cornerB[i];
            end else if (i < 10) begin
                srcB = '0;
            end else if (i < 14) begin
                srcA = -(srcA & 32'hff);
                srcB = 32'd7 + (srcB & 32'h7);
            end
            issue();
        end
        endTest("multiply and divide");

        randomizeFields();
        setPlain();
        inValid = 1'b1;
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        inValid = 1'b0;
        @(negedge clk);
        checkBubble("after flush");
        @(posedge clk);
        #1;
        endTest("flush");

        $display("tests passed %0d, tests failed %0d, failed checks %0d",
                 testsPassed, testsFailed, errCount);
        if (errCount == 0 && testsFailed == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
hdl/mipsPkg.sv
hdl/operandForward.sv
hdl/alu.sv
hdl/multDiv.sv
hdl/execute.sv
hdl/execMemReg.sv
hdl/execUnit.sv
tests/clockGen.sv
tests/execUnitTb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing
TOP       := execUnitTb
FILELIST  := verilog.f

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
